// ==== hw/decode_stage_pkg.sv ====
package decode_stage_pkg;

        // ----------------------------------------
        // Widths and fixed indices.
        // ----------------------------------------

        // Architectural register index, 32 indices.
        localparam int ARCH_REG_W = 5;

        // Physical register index, 46 registers in use.
        localparam int PHY_REG_W = 6;

        // Data word and PC width.
        localparam int WORD_W = 32;

        // Instruction bits 27:24 of a software interrupt.
        localparam logic [3:0] SWI_NIBBLE = 4'hF;

        // Writes to this register are thrown away.
        localparam logic [PHY_REG_W-1:0] PHY_DISCARD = 6'd31;

        // First of the internal scratch registers.
        localparam logic [PHY_REG_W-1:0] PHY_SCRATCH_BASE = 6'd32;

        // ----------------------------------------
        // Encodings.
        // ----------------------------------------

        // CPU mode, as held in the CPSR mode field.
        typedef enum logic [4:0] {
                USR = 5'b10000,
                FIQ = 5'b10001,
                IRQ = 5'b10010,
                SVC = 5'b10011,
                ABT = 5'b10111,
                UND = 5'b11011,
                SYS = 5'b11111
        } cpu_mode_t;

        // Condition codes. NV marks a bubble.
        typedef enum logic [3:0] {
                EQ, NE, CS, CC,
                MI, PL, VS, VC,
                HI, LS, GE, LT,
                GT, LE, AL, NV
        } cond_t;

        // Data processing opcodes. Codes 16 and up are reserved.
        typedef enum logic [4:0] {
                AND, EOR, SUB, RSB,
                ADD, ADC, SBC, RSC,
                TST, TEQ, CMP, CMN,
                ORR, MOV, BIC, MVN
        } alu_op_t;

        // Barrel shifter opcodes.
        typedef enum logic [2:0] {
                LSL, LSR, ASR, ROR, RRC, RORI
        } shift_op_t;

        // ----------------------------------------
        // Records.
        // ----------------------------------------

        // Operand. With imm clear, value holds a register index.
        typedef struct packed {
                logic              imm;
                logic [WORD_W-1:0] value;
        } operand_t;

        // Memory access controls.
        typedef struct packed {
                logic load;
                logic store;
                logic pre_index;
                logic unsigned_byte;
                logic signed_byte;
                logic signed_half;
                logic unsigned_half;
                logic translate;
        } mem_ctrl_t;

        // Decoder output, with architectural indices.
        typedef struct packed {
                logic [ARCH_REG_W-1:0] dest_index;
                operand_t              alu_src;
                alu_op_t               alu_op;
                operand_t              shift_src;
                shift_op_t             shift_op;
                operand_t              shift_len;
                logic                  flag_update;
                logic [ARCH_REG_W-1:0] mem_index;
                mem_ctrl_t             mem;
                logic                  und;
                logic                  switch_mode;
        } decoded_op_t;

        // Exception flags.
        typedef struct packed {
                logic irq;
                logic fiq;
                logic abt;
                logic und;
                logic swi;
        } exc_t;

        // Decoder output after translation to physical indices.
        typedef struct packed {
                logic [PHY_REG_W-1:0] dest_index;
                operand_t             alu_src;
                alu_op_t              alu_op;
                operand_t             shift_src;
                shift_op_t            shift_op;
                operand_t             shift_len;
                logic                 flag_update;
                logic [PHY_REG_W-1:0] mem_index;
                mem_ctrl_t            mem;
                logic                 switch_mode;
        } remap_op_t;

        // Issue record handed to the next stage.
        typedef struct packed {
                cond_t                cond;
                logic [PHY_REG_W-1:0] dest_index;
                operand_t             alu_src;
                alu_op_t              alu_op;
                operand_t             shift_src;
                shift_op_t            shift_op;
                operand_t             shift_len;
                logic                 flag_update;
                logic [PHY_REG_W-1:0] mem_index;
                mem_ctrl_t            mem;
                logic                 switch_mode;
                logic [WORD_W-1:0]    pc;
                logic [WORD_W-1:0]    pc_plus_8;
                exc_t                 exc;
        } issue_op_t;

endpackage

// ==== hw/reg_bank_map.sv ====
module reg_bank_map (
        // Architectural index as extracted by the decoder.
        input  logic [decode_stage_pkg::ARCH_REG_W-1:0] i_arch_index,

        // Current CPU mode.
        input  decode_stage_pkg::cpu_mode_t             i_mode,

        // Index into the physical register file.
        output logic [decode_stage_pkg::PHY_REG_W-1:0]  o_phy_index
);

import decode_stage_pkg::*;

// Index widened to the physical width.
logic [PHY_REG_W-1:0] arch_ext;

assign arch_ext = PHY_REG_W'(i_arch_index);

always_comb
begin
        // r0-r7 and r15 map to themselves in every mode.
        o_phy_index = arch_ext;

        if (i_arch_index >= 5'd30)
        begin
                // Reserved indices go to the discard register.
                o_phy_index = PHY_DISCARD;
        end
        else if (i_arch_index >= 5'd16)
        begin
                // Internal scratch registers, 32 to 45.
                o_phy_index = PHY_SCRATCH_BASE + (arch_ext - 6'd16);
        end
        else if (i_mode == FIQ)
        begin
                // FIQ banks r8-r14 into 16 to 22.
                if (i_arch_index inside {[5'd8:5'd14]})
                begin
                        o_phy_index = arch_ext + 6'd8;
                end
        end
        else if (i_arch_index inside {5'd13, 5'd14})
        begin
                // SP and LR are banked per exception mode.
                case (i_mode)
                IRQ:     o_phy_index = arch_ext + 6'd10;
                SVC:     o_phy_index = arch_ext + 6'd12;
                ABT:     o_phy_index = arch_ext + 6'd14;
                UND:     o_phy_index = arch_ext + 6'd16;
                // USR, SYS and bad encodings share the user bank.
                default: o_phy_index = arch_ext;
                endcase
        end
end

endmodule

// ==== hw/operand_remap.sv ====
module operand_remap (
        // Decoded operation with architectural indices.
        input  decode_stage_pkg::decoded_op_t i_decoded,

        // Current CPU mode, selects the register bank.
        input  decode_stage_pkg::cpu_mode_t   i_mode,

        // Same operation with physical indices.
        output decode_stage_pkg::remap_op_t   o_remapped
);

import decode_stage_pkg::*;

// Translated indices, one per register field.
logic [PHY_REG_W-1:0] dest_phy;
logic [PHY_REG_W-1:0] alu_src_phy;
logic [PHY_REG_W-1:0] shift_src_phy;
logic [PHY_REG_W-1:0] shift_len_phy;
logic [PHY_REG_W-1:0] mem_phy;

// Constants pass on. Register operands take the physical index, flag stays clear.
function automatic operand_t remap_operand(
        input operand_t             src,
        input logic [PHY_REG_W-1:0] phy
);
        operand_t res;

        res = src;
        if (!src.imm)
        begin
                res.value = WORD_W'(phy);
        end
        return res;
endfunction

// ----------------------------------------
// Bank translation.
// ----------------------------------------

reg_bank_map u_map_dest (
        .i_arch_index   (i_decoded.dest_index),
        .i_mode         (i_mode),
        .o_phy_index    (dest_phy)
);

reg_bank_map u_map_alu_src (
        .i_arch_index   (i_decoded.alu_src.value[ARCH_REG_W-1:0]),
        .i_mode         (i_mode),
        .o_phy_index    (alu_src_phy)
);

reg_bank_map u_map_shift_src (
        .i_arch_index   (i_decoded.shift_src.value[ARCH_REG_W-1:0]),
        .i_mode         (i_mode),
        .o_phy_index    (shift_src_phy)
);

reg_bank_map u_map_shift_len (
        .i_arch_index   (i_decoded.shift_len.value[ARCH_REG_W-1:0]),
        .i_mode         (i_mode),
        .o_phy_index    (shift_len_phy)
);

reg_bank_map u_map_mem (
        .i_arch_index   (i_decoded.mem_index),
        .i_mode         (i_mode),
        .o_phy_index    (mem_phy)
);

// ----------------------------------------
// Rebuild the record.
// ----------------------------------------

always_comb
begin
        // Destination and memory data are always registers.
        o_remapped.dest_index  = dest_phy;
        o_remapped.mem_index   = mem_phy;

        o_remapped.alu_src     = remap_operand(i_decoded.alu_src, alu_src_phy);
        o_remapped.shift_src   = remap_operand(i_decoded.shift_src, shift_src_phy);
        o_remapped.shift_len   = remap_operand(i_decoded.shift_len, shift_len_phy);

        // Opcodes and controls pass straight on.
        o_remapped.alu_op      = i_decoded.alu_op;
        o_remapped.shift_op    = i_decoded.shift_op;
        o_remapped.flag_update = i_decoded.flag_update;
        o_remapped.mem         = i_decoded.mem;
        o_remapped.switch_mode = i_decoded.switch_mode;
end

endmodule

// ==== hw/exception_filter.sv ====
module exception_filter (
        // Instruction word, for the SWI nibble.
        input  logic [decode_stage_pkg::WORD_W-1:0] i_instruction,
        input  logic                                i_instruction_valid,

        // Raw interrupt and abort events.
        input  logic                                i_irq,
        input  logic                                i_fiq,
        input  logic                                i_abt,

        // Undefined flag from the decoder.
        input  logic                                i_und,

        // Ranked exception flags.
        output decode_stage_pkg::exc_t              o_exc
);

import decode_stage_pkg::*;

// Abort that belongs to a real instruction.
logic abt_valid;

assign abt_valid = i_abt && i_instruction_valid;

always_comb
begin
        // Abort ranks highest.
        o_exc.abt = abt_valid;

        // FIQ is masked by an abort.
        o_exc.fiq = i_fiq && !abt_valid;

        // IRQ is masked by FIQ and by an abort.
        o_exc.irq = i_irq && !i_fiq && !abt_valid;

        // Note the SWI only when nothing else is pending.
        // Execute decides later if it is taken.
        o_exc.swi = (i_instruction[27:24] == SWI_NIBBLE) && !(i_irq || i_fiq || i_abt);

        o_exc.und = i_und;
end

endmodule

// ==== hw/decode_stage_reg.sv ====
module decode_stage_reg (
        input  logic                                i_clk,
        input  logic                                i_reset,

        // Clear and stall levels, high to low priority.
        input  logic                                i_clear_from_writeback,
        input  logic                                i_data_stall,
        input  logic                                i_clear_from_alu,
        input  logic                                i_stall_from_shifter,
        input  logic                                i_stall_from_issue,

        // Translated operation and ranked exceptions.
        input  decode_stage_pkg::remap_op_t         i_remapped,
        input  decode_stage_pkg::exc_t              i_exc,

        // Instruction word, bits 31:28 give the condition.
        input  logic [decode_stage_pkg::WORD_W-1:0] i_instruction,

        // PC values, clocked out untouched.
        input  logic [decode_stage_pkg::WORD_W-1:0] i_pc,
        input  logic [decode_stage_pkg::WORD_W-1:0] i_pc_plus_8,

        // Registered issue record.
        output decode_stage_pkg::issue_op_t         o_issue
);

import decode_stage_pkg::*;

// Record that a load would capture.
issue_op_t next_issue;

// Outcome of the control priority.
logic take_clear;
logic take_load;

// ----------------------------------------
// Control priority.
// ----------------------------------------

always_comb
begin
        take_clear = 1'b0;
        take_load  = 1'b0;

        if (i_clear_from_writeback)
        begin
                take_clear = 1'b1;
        end
        else if (i_data_stall)
        begin
                // Hold. Beats the ALU clear.
                take_clear = 1'b0;
        end
        else if (i_clear_from_alu)
        begin
                take_clear = 1'b1;
        end
        else if (!(i_stall_from_shifter || i_stall_from_issue))
        begin
                // No stall, so take the new record.
                take_load = 1'b1;
        end
end

// ----------------------------------------
// Next record.
// ----------------------------------------

always_comb
begin
        next_issue.cond        = cond_t'(i_instruction[31:28]);
        next_issue.dest_index  = i_remapped.dest_index;
        next_issue.alu_src     = i_remapped.alu_src;
        next_issue.alu_op      = i_remapped.alu_op;
        next_issue.shift_src   = i_remapped.shift_src;
        next_issue.shift_op    = i_remapped.shift_op;
        next_issue.shift_len   = i_remapped.shift_len;
        next_issue.flag_update = i_remapped.flag_update;
        next_issue.mem_index   = i_remapped.mem_index;
        next_issue.mem         = i_remapped.mem;
        next_issue.switch_mode = i_remapped.switch_mode;
        next_issue.pc          = i_pc;
        next_issue.pc_plus_8   = i_pc_plus_8;
        next_issue.exc         = i_exc;
end

// ----------------------------------------
// Pipeline register.
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                // Empty slot with the never condition.
                o_issue      <= '0;
                o_issue.cond <= NV;
        end
        else if (take_clear)
        begin
                // Bubble. Data fields keep their value.
                o_issue.cond <= NV;
                o_issue.exc  <= '0;
        end
        else if (take_load)
        begin
                o_issue <= next_issue;
        end
end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage (
        input  logic                                i_clk,
        input  logic                                i_reset,

        // Instruction and its decoded fields.
        input  logic [decode_stage_pkg::WORD_W-1:0] i_instruction,
        input  decode_stage_pkg::decoded_op_t       i_decoded,
        input  logic                                i_instruction_valid,

        // Mode from the CPSR.
        input  decode_stage_pkg::cpu_mode_t         i_cpu_mode,

        // PC of this instruction and PC + 8.
        input  logic [decode_stage_pkg::WORD_W-1:0] i_pc,
        input  logic [decode_stage_pkg::WORD_W-1:0] i_pc_plus_8,

        // Interrupt and abort events.
        input  logic                                i_irq,
        input  logic                                i_fiq,
        input  logic                                i_abt,

        // Clear and stall levels, high to low priority.
        input  logic                                i_clear_from_writeback,
        input  logic                                i_data_stall,
        input  logic                                i_clear_from_alu,
        input  logic                                i_stall_from_shifter,
        input  logic                                i_stall_from_issue,

        // Issue record for the next stage.
        output decode_stage_pkg::issue_op_t         o_issue
);

import decode_stage_pkg::*;

// Combinational paths into the register.
remap_op_t remapped;
exc_t      exc;

// Register fields into physical indices.
operand_remap u_operand_remap (
        .i_decoded      (i_decoded),
        .i_mode         (i_cpu_mode),
        .o_remapped     (remapped)
);

// Rank the exceptions.
exception_filter u_exception_filter (
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_abt                  (i_abt),
        .i_und                  (i_decoded.und),
        .o_exc                  (exc)
);

// Output register with clear and stall.
decode_stage_reg u_decode_stage_reg (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_remapped             (remapped),
        .i_exc                  (exc),
        .i_instruction          (i_instruction),
        .i_pc                   (i_pc),
        .i_pc_plus_8            (i_pc_plus_8),
        .o_issue                (o_issue)
);

endmodule

// ==== verif/decode_stage_chk.sv ====
module decode_stage_chk (
        input logic                          i_clk,
        input logic                          i_reset,
        input logic                          i_clear_from_writeback,
        input logic                          i_data_stall,
        input decode_stage_pkg::issue_op_t   o_issue
);

import decode_stage_pkg::*;

// Number of assertion failures so far.
int fail_count = 0;

// Reset leaves a bubble.
a_reset_nv: assert property (@(posedge i_clk) i_reset |=> o_issue.cond == NV)
        else
        begin
                fail_count++;
                $error("cond is not NV one cycle after reset");
        end

// Ranked flags are exclusive.
a_one_exc: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({o_issue.exc.irq, o_issue.exc.fiq, o_issue.exc.abt}))
        else
        begin
                fail_count++;
                $error("more than one of irq, fiq and abt set");
        end

// Writeback clear turns the slot into a bubble.
a_wb_clear: assert property (@(posedge i_clk)
        i_clear_from_writeback |=> (o_issue.cond == NV && o_issue.exc == '0))
        else
        begin
                fail_count++;
                $error("writeback clear did not give a bubble");
        end

// Data stall holds the record.
a_data_stall: assert property (@(posedge i_clk)
        (i_data_stall && !i_reset && !i_clear_from_writeback) |=> $stable(o_issue))
        else
        begin
                fail_count++;
                $error("issue record changed during a data stall");
        end

endmodule

bind decode_stage decode_stage_chk u_decode_stage_chk (.*);

// ==== verif/tb_decode_stage.sv ====
module tb_decode_stage;

import decode_stage_pkg::*;

// Run limit of about ten times the length of all tests.
localparam int TIMEOUT_CYCLES = 2000;

// One set of data inputs for the DUT.
typedef struct packed {
        logic [WORD_W-1:0] instr;
        decoded_op_t       decoded;
        logic              valid;
        cpu_mode_t         mode;
        logic [WORD_W-1:0] pc;
        logic [WORD_W-1:0] pc_plus_8;
        logic              irq;
        logic              fiq;
        logic              abt;
} stim_t;

logic              i_clk;
logic              i_reset;
logic [WORD_W-1:0] i_instruction;
decoded_op_t       i_decoded;
logic              i_instruction_valid;
cpu_mode_t         i_cpu_mode;
logic [WORD_W-1:0] i_pc;
logic [WORD_W-1:0] i_pc_plus_8;
logic              i_irq;
logic              i_fiq;
logic              i_abt;
logic              i_clear_from_writeback;
logic              i_data_stall;
logic              i_clear_from_alu;
logic              i_stall_from_shifter;
logic              i_stall_from_issue;
issue_op_t         o_issue;

int errors;
int checks;
int cycles;

// Register indices and modes swept by the bank test. The last mode is invalid.
int        idx_list [7] = '{0, 8, 13, 14, 15, 20, 31};
cpu_mode_t mode_list[8] = '{USR, FIQ, IRQ, SVC, ABT, UND, SYS, cpu_mode_t'(5'b00000)};

decode_stage u_decode_stage (.*);

// ----------------------------------------
// Clock and run limit.
// ----------------------------------------

initial
begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
end

always @(posedge i_clk)
begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Test failures found");
                $finish;
        end
end

// ----------------------------------------
// Reference model.
// ----------------------------------------

// Physical index from the bank table.
function automatic logic [PHY_REG_W-1:0] expect_phy(
        input logic [ARCH_REG_W-1:0] arch,
        input cpu_mode_t             mode
);
        int n;
        int bank;

        n = int'(arch);
        if (n >= 30)
                return PHY_DISCARD;
        if (n >= 16)
                return PHY_SCRATCH_BASE + PHY_REG_W'(n - 16);
        if (mode == FIQ && n >= 8 && n <= 14)
                return PHY_REG_W'(16 + n - 8);
        if (n == 13 || n == 14)
        begin
                // First physical slot of each SP/LR bank.
                case (mode)
                IRQ:     bank = 23;
                SVC:     bank = 25;
                ABT:     bank = 27;
                UND:     bank = 29;
                default: bank = 13;
                endcase
                return PHY_REG_W'(bank + n - 13);
        end
        return PHY_REG_W'(n);
endfunction

function automatic operand_t expect_operand(input operand_t op, input cpu_mode_t mode);
        operand_t res;

        res = op;
        if (!op.imm)
                res.value = WORD_W'(expect_phy(op.value[ARCH_REG_W-1:0], mode));
        return res;
endfunction

// Abort first, then FIQ, then IRQ.
function automatic exc_t expect_exc(input stim_t s);
        exc_t res;

        res.abt = s.abt & s.valid;
        res.fiq = s.fiq & ~res.abt;
        res.irq = s.irq & ~s.fiq & ~res.abt;
        res.swi = (s.instr[27:24] == SWI_NIBBLE) & ~(s.irq | s.fiq | s.abt);
        res.und = s.decoded.und;
        return res;
endfunction

function automatic issue_op_t expect_issue(input stim_t s);
        issue_op_t res;

        res.cond        = cond_t'(s.instr[31:28]);
        res.dest_index  = expect_phy(s.decoded.dest_index, s.mode);
        res.alu_src     = expect_operand(s.decoded.alu_src, s.mode);
        res.alu_op      = s.decoded.alu_op;
        res.shift_src   = expect_operand(s.decoded.shift_src, s.mode);
        res.shift_op    = s.decoded.shift_op;
        res.shift_len   = expect_operand(s.decoded.shift_len, s.mode);
        res.flag_update = s.decoded.flag_update;
        res.mem_index   = expect_phy(s.decoded.mem_index, s.mode);
        res.mem         = s.decoded.mem;
        res.switch_mode = s.decoded.switch_mode;
        res.pc          = s.pc;
        res.pc_plus_8   = s.pc_plus_8;
        res.exc         = expect_exc(s);
        return res;
endfunction

// Control bits from high to low are writeback clear, data stall, ALU clear,
// shifter stall and issue stall.
function automatic issue_op_t apply_priority(
        input logic [4:0] ctrl,
        input issue_op_t  held,
        input issue_op_t  fresh
);
        issue_op_t res;

        res = held;
        if (ctrl[4] || (!ctrl[3] && ctrl[2]))
        begin
                res.cond = NV;
                res.exc  = '0;
        end
        else if (!ctrl[3] && !ctrl[1] && !ctrl[0])
                res = fresh;
        return res;
endfunction

// ----------------------------------------
// Drive and compare.
// ----------------------------------------

task automatic step();
        @(posedge i_clk);
        #1;
endtask

task automatic drive(input stim_t s);
        i_instruction       = s.instr;
        i_decoded           = s.decoded;
        i_instruction_valid = s.valid;
        i_cpu_mode          = s.mode;
        i_pc                = s.pc;
        i_pc_plus_8         = s.pc_plus_8;
        i_irq               = s.irq;
        i_fiq               = s.fiq;
        i_abt               = s.abt;
endtask

task automatic drive_ctrl(input logic [4:0] ctrl);
        i_clear_from_writeback = ctrl[4];
        i_data_stall           = ctrl[3];
        i_clear_from_alu       = ctrl[2];
        i_stall_from_shifter   = ctrl[1];
        i_stall_from_issue     = ctrl[0];
endtask

task automatic check_issue(input string name, input issue_op_t exp, input issue_op_t act);
        checks++;
        if (act !== exp)
        begin
                errors++;
                $display("Error: %s expected %h actual %h", name, exp, act);
        end
endtask

task automatic check_exc(input string name, input exc_t exp, input exc_t act);
        checks++;
        if (act !== exp)
        begin
                errors++;
                $display("Error: %s expected %h actual %h", name, exp, act);
        end
endtask

task automatic check_phy(
        input string                name,
        input logic [PHY_REG_W-1:0] exp,
        input logic [PHY_REG_W-1:0] act
);
        checks++;
        if (act !== exp)
        begin
                errors++;
                $display("Error: %s expected %h actual %h", name, exp, act);
        end
endtask

// Quiet AL MOV in user mode.
function automatic stim_t base_stim();
        stim_t s;

        s                = '0;
        s.instr          = 32'hE1A0_0000;
        s.decoded.alu_op = MOV;
        s.valid          = 1'b1;
        s.mode           = USR;
        s.pc             = 32'h0000_1000;
        s.pc_plus_8      = 32'h0000_1008;
        return s;
endfunction

function automatic stim_t random_stim();
        stim_t s;

        s                           = base_stim();
        s.instr                     = $urandom;
        s.decoded.dest_index        = ARCH_REG_W'($urandom);
        s.decoded.alu_src.imm       = 1'b1;
        s.decoded.alu_src.value     = $urandom;
        s.decoded.alu_op            = alu_op_t'(5'($urandom % 16));
        s.decoded.shift_src.imm     = 1'b0;
        s.decoded.shift_src.value   = WORD_W'(ARCH_REG_W'($urandom));
        s.decoded.shift_op          = shift_op_t'(3'($urandom % 6));
        s.decoded.shift_len.imm     = 1'b1;
        s.decoded.shift_len.value   = $urandom;
        s.decoded.flag_update       = 1'($urandom);
        s.decoded.mem_index         = ARCH_REG_W'($urandom);
        s.decoded.mem               = 8'($urandom);
        s.decoded.und               = 1'($urandom);
        s.decoded.switch_mode       = 1'($urandom);
        s.mode                      = mode_list[int'($urandom % 7)];
        s.pc                        = $urandom & 32'hFFFF_FFFC;
        s.pc_plus_8                 = s.pc + 32'd8;
        s.irq                       = 1'($urandom);
        s.fiq                       = 1'($urandom);
        s.abt                       = 1'($urandom);
        return s;
endfunction

// ----------------------------------------
// Tests.
// ----------------------------------------

task automatic test_reset();
        issue_op_t exp;

        exp      = '0;
        exp.cond = NV;
        check_issue("o_issue after reset", exp, o_issue);
endtask

task automatic test_bank();
        stim_t s;
        string tag;

        foreach (mode_list[m])
        begin
                foreach (idx_list[i])
                begin
                        s                         = base_stim();
                        s.mode                    = mode_list[m];
                        s.decoded.dest_index      = ARCH_REG_W'(idx_list[i]);
                        s.decoded.alu_src.value   = WORD_W'(idx_list[i]);
                        s.decoded.shift_src.value = WORD_W'(idx_list[i]);
                        s.decoded.shift_len.value = WORD_W'(idx_list[i]);
                        s.decoded.mem_index       = ARCH_REG_W'(idx_list[i]);
                        drive(s);
                        step();
                        tag = $sformatf("mode %b r%0d", s.mode, idx_list[i]);
                        check_phy({"o_issue.dest_index ", tag},
                                  expect_phy(s.decoded.dest_index, s.mode),
                                  o_issue.dest_index);
                        check_phy({"o_issue.mem_index ", tag},
                                  expect_phy(s.decoded.mem_index, s.mode),
                                  o_issue.mem_index);
                        check_issue({"o_issue ", tag}, expect_issue(s), o_issue);
                end
        end
endtask

// Immediates sit next to register operands.
task automatic test_immediate();
        stim_t s;

        repeat (12)
        begin
                s = random_stim();
                drive(s);
                step();
                check_issue("o_issue immediate", expect_issue(s), o_issue);
        end
endtask

task automatic test_exceptions();
        stim_t s;

        for (int v = 0; v < 2; v++)
        begin
                for (int e = 0; e < 8; e++)
                begin
                        for (int w = 0; w < 2; w++)
                        begin
                                s                   = base_stim();
                                s.valid             = v[0];
                                {s.irq, s.fiq, s.abt} = e[2:0];
                                s.instr[27:24]      = w[0] ? SWI_NIBBLE : 4'h1;
                                s.decoded.und       = e[0] ^ w[0];
                                drive(s);
                                step();
                                check_exc($sformatf("o_issue.exc v%0d e%0d swi%0d", v, e, w),
                                          expect_exc(s), o_issue.exc);
                        end
                end
        end
endtask

// Each control alone and in pairs, then a long stall and its release.
task automatic test_priority();
        stim_t     a;
        stim_t     b;
        issue_op_t held;

        a             = random_stim();
        a.instr[31:28] = 4'hE;
        a.irq         = 1'b1;
        a.fiq         = 1'b0;
        a.abt         = 1'b0;
        b             = random_stim();
        held          = expect_issue(a);
        for (int c = 1; c < 32; c++)
        begin
                if ($countones(c) <= 2)
                begin
                        drive(a);
                        drive_ctrl(5'b00000);
                        step();
                        check_issue("o_issue reload", held, o_issue);
                        drive(b);
                        drive_ctrl(c[4:0]);
                        step();
                        check_issue($sformatf("o_issue ctrl %b", c[4:0]),
                                    apply_priority(c[4:0], held, expect_issue(b)), o_issue);
                end
        end
        drive(a);
        drive_ctrl(5'b00000);
        step();
        drive(b);
        drive_ctrl(5'b01000);
        repeat (3)
        begin
                step();
                check_issue("o_issue long stall", held, o_issue);
        end
        drive_ctrl(5'b00000);
        step();
        check_issue("o_issue after release", expect_issue(b), o_issue);
endtask

// ----------------------------------------
// Main sequence.
// ----------------------------------------

initial
begin
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        void'($urandom(32'h4834));
        i_reset    = 1'b1;
        drive(base_stim());
        drive_ctrl(5'b00000);
        repeat (4) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        test_reset();
        test_bank();
        test_immediate();
        test_exceptions();
        test_priority();

        // Assertion failures of the bound checker count as errors too.
        errors = errors + u_decode_stage.u_decode_stage_chk.fail_count;

        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0)
                $display("All tests passed!");
        else
                $display("Test failures found");
        $finish;
end

endmodule

// ==== src.f ====
hw/decode_stage_pkg.sv
hw/reg_bank_map.sv
hw/operand_remap.sv
hw/exception_filter.sv
hw/decode_stage_reg.sv
hw/decode_stage.sv
verif/decode_stage_chk.sv
verif/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hw/decode_stage_pkg.sv
  - hw/reg_bank_map.sv
  - hw/operand_remap.sv
  - hw/exception_filter.sv
  - hw/decode_stage_reg.sv
  - hw/decode_stage.sv
  - target: simulation
    files:
      - verif/decode_stage_chk.sv
      - verif/tb_decode_stage.sv
